/* soc_map_pkg.sv */
// CPU bus widths, register map and interrupt numbering, imported by the register and IRQ blocks
`default_nettype none

package soc_map_pkg;

    ////////////////////
    // CPU bus
    ////////////////////
    localparam int BUS_ADDR_W = 16;
    localparam int BUS_DATA_W = 8;

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    ////////////////////
    // Register addresses
    ////////////////////
    // Interrupt enable, plain read/write
    localparam bus_addr_t ADDR_IEN      = 16'h0600;
    // Interrupt status, write one to clear
    localparam bus_addr_t ADDR_ISR      = 16'h0601;
    localparam bus_addr_t ADDR_SPI_CTRL = 16'h060A;
    // Write starts a byte, read returns last received byte
    localparam bus_addr_t ADDR_SPI_DATA = 16'h060B;

    ////////////////////
    // Interrupt sources
    ////////////////////
    localparam int IRQ_SRC_COUNT = 4;

    typedef logic [IRQ_SRC_COUNT-1:0] irq_vec_t;

    // Sticky sources, one bit each in IEN and ISR
    localparam int IRQ_VBLANK    = 0;
    localparam int IRQ_LINE      = 1;
    localparam int IRQ_XFER_DONE = 2;
    localparam int IRQ_SOF       = 3;

    ////////////////////
    // SPI_CTRL fields
    ////////////////////
    // Device select sits in the low bits
    localparam int SPI_CTRL_SLOW_BIT    = 2;
    localparam int SPI_CTRL_AUTO_TX_BIT = 3;
    // Read only
    localparam int SPI_CTRL_BUSY_BIT    = 7;

endpackage

`default_nettype wire

/* spi_pkg.sv */
// SPI device select encoding and byte type, imported by the SPI master and its register block
`default_nettype none

package spi_pkg;

    // Device select field of SPI_CTRL
    typedef enum logic [1:0] {
        SPI_SEL_NONE  = 2'd0,
        SPI_SEL_SD    = 2'd1,
        SPI_SEL_FLASH = 2'd2,
        // Reserved, no device selected
        SPI_SEL_RSVD  = 2'd3
    } spi_sel_t;

    typedef logic [7:0] spi_byte_t;

    // Clocked out on auto-transmit so a read pulls in the next byte
    localparam spi_byte_t SPI_FILL_BYTE = 8'hFF;

endpackage

`default_nettype wire

/* spi_ctrl_if.sv */
// Byte-level control link from the register block to the SPI master, one instance per SPI port
`default_nettype none

interface spi_ctrl_if
    import spi_pkg::*;
();

    // Request side
    spi_byte_t txdata;
    logic      txstart;
    logic      slow;
    spi_sel_t  select;

    // Status side, rxdata valid once busy drops
    spi_byte_t rxdata;
    logic      busy;

    modport regs (
        output txdata,
        output txstart,
        output slow,
        output select,
        input  rxdata,
        input  busy
    );

    modport master (
        input  txdata,
        input  txstart,
        input  slow,
        input  select,
        output rxdata,
        output busy
    );

endinterface

`default_nettype wire

/* irq_if.sv */
// Register access link from the CPU decode block to the interrupt controller
`default_nettype none

interface irq_if
    import soc_map_pkg::*;
();

    // Single-cycle strobes in the cycle of the CPU write
    logic      ien_write;
    logic      isr_clear;
    bus_data_t wrdata;

    // Current register contents for readback
    irq_vec_t  ien;
    irq_vec_t  isr;

    modport regs (
        output ien_write,
        output isr_clear,
        output wrdata,
        input  ien,
        input  isr
    );

    modport ctrl (
        input  ien_write,
        input  isr_clear,
        input  wrdata,
        output ien,
        output isr
    );

endinterface

`default_nettype wire

/* periph_regs.sv */
// CPU register decode for the IO block: SPI control and data, IRQ register strobes, read mux
`default_nettype none

module periph_regs
    import soc_map_pkg::*;
    import spi_pkg::*;
(
    input  logic       sys_clk,
    input  logic       sys_rst,

    // CPU bus
    input  bus_addr_t  bus_addr,
    input  bus_data_t  bus_wrdata,
    input  logic       bus_write,
    output bus_data_t  bus_rddata,

    spi_ctrl_if.regs   spi,
    irq_if.regs        irq
);

    bus_addr_t addr_r;

    // SPI_CTRL fields
    logic      auto_tx_r;
    logic      slow_r;
    spi_sel_t  select_r;

    // Byte handed to the SPI master
    spi_byte_t txdata_r;
    logic      txstart_r;

    logic      data_read;

    ////////////////////
    // Write decode
    ////////////////////
    assign irq.ien_write = bus_write && (bus_addr == ADDR_IEN);
    assign irq.isr_clear = bus_write && (bus_addr == ADDR_ISR);
    assign irq.wrdata    = bus_wrdata;

    // Read of SPI_DATA, used to fire a fill byte in auto-transmit mode
    assign data_read = !bus_write && (bus_addr == ADDR_SPI_DATA);

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            addr_r    <= '0;
            auto_tx_r <= 1'b0;
            slow_r    <= 1'b0;
            select_r  <= SPI_SEL_NONE;
            txdata_r  <= '0;
            txstart_r <= 1'b0;
        end else begin
            addr_r    <= bus_addr;
            txstart_r <= 1'b0;

            if (bus_write && bus_addr == ADDR_SPI_CTRL) begin
                auto_tx_r <= bus_wrdata[SPI_CTRL_AUTO_TX_BIT];
                slow_r    <= bus_wrdata[SPI_CTRL_SLOW_BIT];
                select_r  <= spi_sel_t'(bus_wrdata[$bits(spi_sel_t)-1:0]);
            end

            if (bus_write && bus_addr == ADDR_SPI_DATA) begin
                txdata_r  <= bus_wrdata;
                txstart_r <= 1'b1;
            end else if (data_read && auto_tx_r) begin
                // Next byte clocks in while the CPU takes this one
                txdata_r  <= SPI_FILL_BYTE;
                txstart_r <= 1'b1;
            end
        end
    end

    assign spi.txdata  = txdata_r;
    assign spi.txstart = txstart_r;
    assign spi.slow    = slow_r;
    assign spi.select  = select_r;

    ////////////////////
    // Read mux
    ////////////////////
    // Answered the cycle after the request, from the registered address
    always_comb begin
        bus_rddata = '0;
        case (addr_r)
            ADDR_IEN: begin
                bus_rddata[IRQ_SRC_COUNT-1:0] = irq.ien;
            end
            ADDR_ISR: begin
                bus_rddata[IRQ_SRC_COUNT-1:0] = irq.isr;
            end
            ADDR_SPI_CTRL: begin
                bus_rddata[SPI_CTRL_BUSY_BIT]        = spi.busy;
                bus_rddata[SPI_CTRL_AUTO_TX_BIT]     = auto_tx_r;
                bus_rddata[SPI_CTRL_SLOW_BIT]        = slow_r;
                bus_rddata[$bits(spi_sel_t)-1:0]     = select_r;
            end
            ADDR_SPI_DATA: begin
                bus_rddata = spi.rxdata;
            end
            default: begin
                bus_rddata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* irq_ctrl.sv */
// Interrupt enable and sticky status registers, combines them into the CPU interrupt request
`default_nettype none

module irq_ctrl
    import soc_map_pkg::*;
(
    input  logic     sys_clk,
    input  logic     sys_rst,

    // One-cycle event pulses, one per source
    input  irq_vec_t irq_event,

    irq_if.ctrl      irq_bus,

    output logic     irq
);

    irq_vec_t ien_r;
    irq_vec_t isr_r;
    irq_vec_t clr_mask;

    // Write one to clear, only during an ISR write
    assign clr_mask = irq_bus.isr_clear ? irq_bus.wrdata[IRQ_SRC_COUNT-1:0] : '0;

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            ien_r <= '0;
            isr_r <= '0;
        end else begin
            if (irq_bus.ien_write) begin
                ien_r <= irq_bus.wrdata[IRQ_SRC_COUNT-1:0];
            end
            // A new event wins over a clear of the same bit
            isr_r <= (isr_r & ~clr_mask) | irq_event;
        end
    end

    assign irq_bus.ien = ien_r;
    assign irq_bus.isr = isr_r;

    assign irq = |(isr_r & ien_r);

endmodule

`default_nettype wire

/* spi_master.sv */
// SPI mode 0 byte engine with selectable clock rate, routed to the SD card or the flash pins
`default_nettype none

module spi_master
    import spi_pkg::*;
#(
    // SCK half-period in sys_clk cycles
    parameter int FAST_HALF = 2,
    parameter int SLOW_HALF = 8
) (
    input  logic        sys_clk,
    input  logic        sys_rst,

    spi_ctrl_if.master  spi,

    // SD card
    output logic        sd_sck,
    output logic        sd_mosi,
    output logic        sd_ssel_n,
    input  logic        sd_miso,

    // Flash
    output logic        flash_sck,
    output logic        flash_mosi,
    output logic        flash_ssel_n,
    input  logic        flash_miso
);

    localparam int MAX_HALF = (SLOW_HALF > FAST_HALF) ? SLOW_HALF : FAST_HALF;
    localparam int CNT_W    = $clog2(MAX_HALF) + 1;

    logic             busy_r;
    logic             slow_r;
    logic             sck_r;
    logic             miso_s;
    spi_byte_t        shreg;
    logic [2:0]       bit_cnt;
    logic [CNT_W-1:0] div_cnt;
    logic [CNT_W-1:0] half_lim;

    logic             sel_sd;
    logic             sel_flash;
    logic             spi_mosi;
    logic             spi_miso;

    // Rate latched at start so a mid-byte SPI_CTRL write cannot skew SCK
    assign half_lim = slow_r ? CNT_W'(SLOW_HALF - 1) : CNT_W'(FAST_HALF - 1);

    ////////////////////
    // Shift engine
    ////////////////////
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            busy_r  <= 1'b0;
            slow_r  <= 1'b0;
            sck_r   <= 1'b0;
            miso_s  <= 1'b0;
            shreg   <= '0;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (!busy_r) begin
            // Starts while busy are dropped
            if (spi.txstart) begin
                busy_r  <= 1'b1;
                slow_r  <= spi.slow;
                shreg   <= spi.txdata;
                bit_cnt <= '0;
                div_cnt <= '0;
                sck_r   <= 1'b0;
            end
        end else if (div_cnt == half_lim) begin
            div_cnt <= '0;
            sck_r   <= !sck_r;
            if (!sck_r) begin
                // Rising edge, sample MISO
                miso_s <= spi_miso;
            end else begin
                // Falling edge, next bit onto MOSI
                shreg   <= {shreg[6:0], miso_s};
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    busy_r <= 1'b0;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // MSB first, held low between bytes
    assign spi_mosi = busy_r && shreg[7];

    // Shift register holds the received byte once idle
    assign spi.rxdata = shreg;
    assign spi.busy   = busy_r;

    ////////////////////
    // Pin routing
    ////////////////////
    assign sel_sd    = (spi.select == SPI_SEL_SD);
    assign sel_flash = (spi.select == SPI_SEL_FLASH);

    assign sd_ssel_n    = !sel_sd;
    assign flash_ssel_n = !sel_flash;

    // SD pins get the clock unless flash is selected
    assign sd_sck     = sck_r && !sel_flash;
    assign sd_mosi    = spi_mosi && !sel_flash;
    assign flash_sck  = sck_r && sel_flash;
    assign flash_mosi = spi_mosi && sel_flash;

    assign spi_miso = sel_flash ? flash_miso : sd_miso;

endmodule

`default_nettype wire

/* soc_io_top.sv */
// Top level of the IO block: CPU register bus, SPI pins and interrupt request as plain ports
`default_nettype none

module soc_io_top
    import soc_map_pkg::*;
#(
    parameter int FAST_HALF = 2,
    parameter int SLOW_HALF = 8
) (
    input  logic      sys_clk,
    input  logic      sys_rst,

    // CPU bus
    input  bus_addr_t bus_addr,
    input  bus_data_t bus_wrdata,
    input  logic      bus_write,
    output bus_data_t bus_rddata,

    // Interrupts
    input  irq_vec_t  irq_event,
    output logic      irq,

    // SD card
    output logic      sd_sck,
    output logic      sd_mosi,
    output logic      sd_ssel_n,
    input  logic      sd_miso,

    // Flash
    output logic      flash_sck,
    output logic      flash_mosi,
    output logic      flash_ssel_n,
    input  logic      flash_miso
);

    spi_ctrl_if spi_ctrl ();
    irq_if      irq_bus ();

    ////////////////////
    // Register decode
    ////////////////////
    periph_regs periph_regs_inst (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .bus_addr   (bus_addr),
        .bus_wrdata (bus_wrdata),
        .bus_write  (bus_write),
        .bus_rddata (bus_rddata),
        .spi        (spi_ctrl.regs),
        .irq        (irq_bus.regs)
    );

    ////////////////////
    // Interrupts
    ////////////////////
    irq_ctrl irq_ctrl_inst (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .irq_event (irq_event),
        .irq_bus   (irq_bus.ctrl),
        .irq       (irq)
    );

    ////////////////////
    // SPI
    ////////////////////
    spi_master #(
        .FAST_HALF (FAST_HALF),
        .SLOW_HALF (SLOW_HALF)
    ) spi_master_inst (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .spi          (spi_ctrl.master),
        .sd_sck       (sd_sck),
        .sd_mosi      (sd_mosi),
        .sd_ssel_n    (sd_ssel_n),
        .sd_miso      (sd_miso),
        .flash_sck    (flash_sck),
        .flash_mosi   (flash_mosi),
        .flash_ssel_n (flash_ssel_n),
        .flash_miso   (flash_miso)
    );

endmodule

`default_nettype wire

/* tb_soc_io_checker.sv */
// Testbench checker for the IO block: SPI slave models, interrupt register model, value compares
`default_nettype none

module tb_soc_io_checker
    import soc_map_pkg::*;
(
    input  logic      sys_clk,
    input  logic      sys_rst,
    input  bus_addr_t bus_addr,
    input  bus_data_t bus_wrdata,
    input  logic      bus_write,
    input  irq_vec_t  irq_event,
    input  logic      irq,
    input  logic      sd_sck,
    input  logic      sd_mosi,
    input  logic      sd_ssel_n,
    output logic      sd_miso,
    input  logic      flash_sck,
    input  logic      flash_mosi,
    input  logic      flash_ssel_n,
    output logic      flash_miso
);

    integer     error_count = 0;
    integer     check_count = 0;

    // Slave state
    logic [7:0] sd_tx = 8'h00;
    logic [7:0] sd_rx = 8'h00;
    logic [7:0] flash_tx = 8'h00;
    logic [7:0] flash_rx = 8'h00;
    logic       active = 1'b0;
    logic       use_flash = 1'b0;

    // SCK half-period measurement
    integer     half_min = 0;
    integer     half_max = 0;
    integer     run_len = 0;
    logic       edge_seen = 1'b0;
    logic       sck_prev = 1'b0;
    logic       cur_sck;

    // Interrupt register model
    irq_vec_t   ien_model;
    irq_vec_t   isr_model;
    irq_vec_t   clr;

    assign sd_miso    = sd_tx[7];
    assign flash_miso = flash_tx[7];

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        check_count = check_count + 1;
        if (exp !== act) begin
            error_count = error_count + 1;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Loads the slave's reply byte before a transfer starts
    task automatic arm(input logic flash, input logic [7:0] reply);
        use_flash = flash;
        if (flash) begin
            flash_tx = reply;
            flash_rx = 8'h00;
        end else begin
            sd_tx = reply;
            sd_rx = 8'h00;
        end
        half_min  = 1000;
        half_max  = 0;
        run_len   = 0;
        edge_seen = 1'b0;
        sck_prev  = 1'b0;
        active    = 1'b1;
    endtask

    task automatic disarm();
        active = 1'b0;
    endtask

    ////////////////////
    // SPI slaves, mode 0
    ////////////////////
    // A slave only takes in MOSI while its select is low
    always @(posedge sd_sck) begin
        if (!sd_ssel_n) begin
            sd_rx <= {sd_rx[6:0], sd_mosi};
        end
    end
    always @(negedge sd_sck) sd_tx <= {sd_tx[6:0], 1'b0};
    always @(posedge flash_sck) begin
        if (!flash_ssel_n) begin
            flash_rx <= {flash_rx[6:0], flash_mosi};
        end
    end
    always @(negedge flash_sck) flash_tx <= {flash_tx[6:0], 1'b0};

    always @(negedge sys_clk) begin
        if (active) begin
            cur_sck = use_flash ? flash_sck : sd_sck;
            if ((use_flash ? sd_sck : flash_sck) !== 1'b0) begin
                error_count = error_count + 1;
                $display("SCK of the unselected device toggled during a transfer");
            end
            if (cur_sck !== sck_prev) begin
                if (edge_seen) begin
                    if (run_len < half_min) half_min = run_len;
                    if (run_len > half_max) half_max = run_len;
                end
                edge_seen = 1'b1;
                run_len   = 1;
            end else begin
                run_len = run_len + 1;
            end
            sck_prev = cur_sck;
        end
    end

    ////////////////////
    // Interrupt model
    ////////////////////
    always @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            ien_model = '0;
            isr_model = '0;
        end else begin
            clr = (bus_write && bus_addr == ADDR_ISR) ? bus_wrdata[IRQ_SRC_COUNT-1:0] : '0;
            if (bus_write && bus_addr == ADDR_IEN) ien_model = bus_wrdata[IRQ_SRC_COUNT-1:0];
            isr_model = (isr_model & ~clr) | irq_event;
        end
    end

    always @(negedge sys_clk) begin
        if (!sys_rst) compare("irq_output", {15'd0, |(isr_model & ien_model)}, {15'd0, irq});
    end

endmodule

`default_nettype wire

/* tb_soc_io.sv */
// Testbench top for the IO block: clock, reset, bus tasks and random SPI and interrupt stimulus
`default_nettype none

module tb_soc_io
    import soc_map_pkg::*;
    import spi_pkg::*;
;
    localparam int FAST_HALF = 2;
    localparam int SLOW_HALF = 8;
    localparam int POLL_LIMIT = 500;

    logic      sys_clk = 1'b0;
    logic      sys_rst = 1'b1;
    bus_addr_t bus_addr = '0;
    bus_data_t bus_wrdata = '0;
    logic      bus_write = 1'b0;
    bus_data_t bus_rddata;
    irq_vec_t  irq_event = '0;
    logic      irq;
    wire       sd_sck, sd_mosi, sd_ssel_n, sd_miso;
    wire       flash_sck, flash_mosi, flash_ssel_n, flash_miso;

    integer    seed = 12979;
    integer    i, k, m;
    bus_data_t rd;
    bus_data_t tx_byte;
    bus_data_t reply;
    bus_addr_t addr;

    always #5 sys_clk = !sys_clk;

    soc_io_top #(.FAST_HALF(FAST_HALF), .SLOW_HALF(SLOW_HALF)) soc_io_top_inst (
        .sys_clk(sys_clk), .sys_rst(sys_rst), .bus_addr(bus_addr), .bus_wrdata(bus_wrdata),
        .bus_write(bus_write), .bus_rddata(bus_rddata), .irq_event(irq_event), .irq(irq),
        .sd_sck(sd_sck), .sd_mosi(sd_mosi), .sd_ssel_n(sd_ssel_n), .sd_miso(sd_miso),
        .flash_sck(flash_sck), .flash_mosi(flash_mosi), .flash_ssel_n(flash_ssel_n),
        .flash_miso(flash_miso)
    );

    tb_soc_io_checker checker_inst (
        .sys_clk(sys_clk), .sys_rst(sys_rst), .bus_addr(bus_addr), .bus_wrdata(bus_wrdata),
        .bus_write(bus_write), .irq_event(irq_event), .irq(irq),
        .sd_sck(sd_sck), .sd_mosi(sd_mosi), .sd_ssel_n(sd_ssel_n), .sd_miso(sd_miso),
        .flash_sck(flash_sck), .flash_mosi(flash_mosi), .flash_ssel_n(flash_ssel_n),
        .flash_miso(flash_miso)
    );

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic bus_wr(input bus_addr_t a, input bus_data_t d);
        @(negedge sys_clk);
        bus_addr   = a;
        bus_wrdata = d;
        bus_write  = 1'b1;
        @(negedge sys_clk);
        bus_write  = 1'b0;
        bus_addr   = '0;
    endtask

    // Idle address is 0x0000 so an SPI_DATA read fires only once
    task automatic bus_rd(input bus_addr_t a, output bus_data_t d);
        @(negedge sys_clk);
        bus_addr  = a;
        bus_write = 1'b0;
        @(negedge sys_clk);
        d        = bus_rddata;
        bus_addr = '0;
    endtask

    task automatic wait_spi_idle();
        integer n;
        bus_data_t s;
        n = 0;
        @(negedge sys_clk);
        bus_rd(ADDR_SPI_CTRL, s);
        while (s[SPI_CTRL_BUSY_BIT] && n < POLL_LIMIT) begin
            bus_rd(ADDR_SPI_CTRL, s);
            n = n + 1;
        end
        if (n >= POLL_LIMIT) abort_run("SPI busy never cleared");
    endtask

    // One byte to the chosen device, checking MOSI, MISO and SCK timing
    task automatic spi_transfer(input logic flash, input logic slow);
        bus_data_t r;
        tx_byte = $random(seed);
        reply   = $random(seed);
        bus_wr(ADDR_SPI_CTRL, {5'd0, slow, flash ? SPI_SEL_FLASH : SPI_SEL_SD});
        checker_inst.compare("ssel_n", {14'd0, flash, !flash}, {14'd0, sd_ssel_n, flash_ssel_n});
        checker_inst.arm(flash, reply);
        bus_wr(ADDR_SPI_DATA, tx_byte);
        wait_spi_idle();
        checker_inst.disarm();
        checker_inst.compare("mosi_capture", tx_byte,
                             flash ? checker_inst.flash_rx : checker_inst.sd_rx);
        bus_rd(ADDR_SPI_DATA, r);
        checker_inst.compare("spi_rxdata", reply, r);
        checker_inst.compare("half_min", slow ? SLOW_HALF : FAST_HALF, checker_inst.half_min);
        checker_inst.compare("half_max", slow ? SLOW_HALF : FAST_HALF, checker_inst.half_max);
    endtask

    initial begin
        #2000000;
        abort_run("simulation watchdog expired");
    end

    initial begin
        repeat (8) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst = 1'b0;

        // Reset values
        bus_rd(ADDR_IEN, rd);
        checker_inst.compare("reset_ien", 8'h00, rd);
        bus_rd(ADDR_ISR, rd);
        checker_inst.compare("reset_isr", 8'h00, rd);
        bus_rd(ADDR_SPI_CTRL, rd);
        checker_inst.compare("reset_spi_ctrl", 8'h00, rd);
        checker_inst.compare("reset_pins", 16'h000C,
                             {10'd0, irq, sd_sck, sd_ssel_n, flash_ssel_n, flash_sck, 1'b0});

        // Register readback
        for (i = 0; i < 8; i = i + 1) begin
            tx_byte = $random(seed);
            bus_wr(ADDR_IEN, tx_byte);
            bus_rd(ADDR_IEN, rd);
            checker_inst.compare("ien_readback", {4'd0, tx_byte[3:0]}, rd);
            tx_byte = $random(seed);
            bus_wr(ADDR_SPI_CTRL, tx_byte);
            bus_rd(ADDR_SPI_CTRL, rd);
            checker_inst.compare("spi_ctrl_readback", {4'd0, tx_byte[3:0]}, rd);
            addr = $random(seed);
            if (addr == ADDR_IEN || addr == ADDR_ISR || addr == ADDR_SPI_CTRL ||
                addr == ADDR_SPI_DATA) addr = 16'h0605;
            bus_rd(addr, rd);
            checker_inst.compare("unmapped_read", 8'h00, rd);
        end
        bus_wr(ADDR_IEN, 8'h00);

        // SPI transfers, both devices and both rates
        for (k = 0; k < 4; k = k + 1) begin
            for (i = 0; i < 3; i = i + 1) spi_transfer(k[0], k[1]);
        end

        // Auto-transmit on each device
        for (k = 0; k < 2; k = k + 1) begin
            reply = $random(seed);
            bus_wr(ADDR_SPI_CTRL, {4'd0, 2'b10, k[0] ? SPI_SEL_FLASH : SPI_SEL_SD});
            checker_inst.arm(k[0], reply);
            bus_rd(ADDR_SPI_DATA, rd);
            wait_spi_idle();
            checker_inst.disarm();
            checker_inst.compare("auto_tx_fill", 8'hFF,
                                 k[0] ? checker_inst.flash_rx : checker_inst.sd_rx);
            checker_inst.arm(k[0], $random(seed));
            bus_rd(ADDR_SPI_DATA, rd);
            checker_inst.compare("auto_tx_rxdata", reply, rd);
            wait_spi_idle();
            checker_inst.disarm();
            bus_wr(ADDR_SPI_CTRL, 8'h00);
        end

        // Random events and enables against the sticky model
        for (i = 0; i < 200; i = i + 1) begin
            @(negedge sys_clk);
            irq_event  = $random(seed);
            m          = $random(seed) & 7;
            bus_write  = (m < 2);
            bus_addr   = (m == 0) ? ADDR_IEN : ADDR_ISR;
            bus_wrdata = $random(seed);
            if (i % 10 == 9) begin
                @(negedge sys_clk);
                irq_event = '0;
                bus_write = 1'b0;
                bus_rd(ADDR_ISR, rd);
                checker_inst.compare("isr_model", {4'd0, checker_inst.isr_model}, rd);
                bus_rd(ADDR_IEN, rd);
                checker_inst.compare("ien_model", {4'd0, checker_inst.ien_model}, rd);
            end
        end
        @(negedge sys_clk);
        irq_event = '0;
        bus_write = 1'b0;
        bus_addr  = '0;

        // Clear removes only written bits, a coinciding pulse wins
        bus_wr(ADDR_ISR, 8'h0F);
        @(negedge sys_clk);
        irq_event = 4'hF;
        @(negedge sys_clk);
        irq_event = '0;
        bus_wr(ADDR_ISR, 8'h05);
        bus_rd(ADDR_ISR, rd);
        checker_inst.compare("w1c_partial", 8'h0A, rd);
        @(negedge sys_clk);
        irq_event  = 4'h2;
        bus_addr   = ADDR_ISR;
        bus_wrdata = 8'h0A;
        bus_write  = 1'b1;
        @(negedge sys_clk);
        irq_event = '0;
        bus_write = 1'b0;
        bus_addr  = '0;
        bus_rd(ADDR_ISR, rd);
        checker_inst.compare("pulse_beats_clear", 8'h02, rd);

        repeat (4) @(negedge sys_clk);
        $display("Checks: %0d, errors: %0d", checker_inst.check_count, checker_inst.error_count);
        if (checker_inst.error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* soc_io.f */
soc_map_pkg.sv
spi_pkg.sv
spi_ctrl_if.sv
irq_if.sv
periph_regs.sv
irq_ctrl.sv
spi_master.sv
soc_io_top.sv
tb_soc_io_checker.sv
tb_soc_io.sv
